/* hdl/macc_consts.svh */
// ------------------------------
// widths are fixed project-wide, no module overrides them
// READ_LATENCY must match the pad RAM pipeline depth
// ------------------------------
`ifndef MACC_CONSTS_SVH
`define MACC_CONSTS_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define MACC_DATA_WIDTH 16 // ifmap, weight, external psum
`define MACC_LEN_WIDTH 4 // conv length count
`define MACC_FILT_WIDTH 4 // filter / channel count

// 2*data + len, so 15 products of full-scale operands never overflow
`define MACC_ACC_WIDTH (2*`MACC_DATA_WIDTH + `MACC_LEN_WIDTH)

// ------------------------------
// pad interface
// ------------------------------
`define MACC_READ_LATENCY 2 // address to data, in cycles

`endif

/* hdl/macc_pkg.sv */
// ------------------------------
// shared types of the MAC processing element
// ------------------------------
`default_nettype none

`include "macc_consts.svh"

package macc_pkg;

  // ------------------------------
  // data and count types
  // ------------------------------
  typedef logic signed [`MACC_DATA_WIDTH-1:0] data_t; // pad word
  typedef logic signed [`MACC_ACC_WIDTH-1:0] acc_t; // accumulator word
  typedef logic [`MACC_LEN_WIDTH-1:0] len_t; // index within one sum
  typedef logic [`MACC_FILT_WIDTH-1:0] filt_t; // filter or channel index

  // ------------------------------
  // sequencer FSM
  // ------------------------------
  typedef enum logic [2:0] {
    IDLE = 3'b000,
    MUL_RUN = 3'b001, // issuing weight/ifmap pairs
    MUL_END = 3'b011, // gap cycle between filters
    ACC_RUN = 3'b101, // issuing psum pairs
    ACC_END = 3'b100
  } seq_state_t;

endpackage

`default_nettype wire

/* hdl/psum_sequencer.sv */
// ------------------------------
// begin pulses only act in IDLE, both high together starts nothing
// conv_len and filter_num must be held stable for the whole run
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "macc_consts.svh"

module psum_sequencer (
  input logic clk,
  input logic rst_n,
  input logic mac_begin,
  input logic acc_begin,
  input macc_pkg::len_t conv_len,
  input macc_pkg::filt_t filter_num,
  output logic issue,
  output logic issue_first,
  output logic issue_last,
  output logic issue_acc,
  output logic issue_end,
  output logic mul_enable,
  output logic acc_enable,
  output macc_pkg::len_t cnt_a,
  output macc_pkg::filt_t cnt_b
);

  macc_pkg::seq_state_t state_q;
  macc_pkg::seq_state_t state_d;
  macc_pkg::len_t len_last;
  macc_pkg::filt_t filt_last;
  logic a_at_len; // last pair of the current sum
  logic b_at_filt; // last filter of the sweep
  logic a_at_filt; // last channel of the accumulation

  assign len_last = conv_len - 1'b1;
  assign filt_last = filter_num - 1'b1;

  assign a_at_len = (cnt_a == len_last);
  assign b_at_filt = (cnt_b == filt_last);
  assign a_at_filt = (cnt_a == filt_last);

  // ------------------------------
  // state register and next state
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= macc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      macc_pkg::IDLE: begin
        if (mac_begin && !acc_begin) begin
          state_d = macc_pkg::MUL_RUN;
        end else if (acc_begin && !mac_begin) begin
          state_d = macc_pkg::ACC_RUN;
        end
      end
      macc_pkg::MUL_RUN: begin
        if (a_at_len) begin
          state_d = macc_pkg::MUL_END;
        end
      end
      macc_pkg::MUL_END: begin
        state_d = b_at_filt ? macc_pkg::IDLE : macc_pkg::MUL_RUN;
      end
      macc_pkg::ACC_RUN: begin
        if (a_at_filt) begin
          state_d = macc_pkg::ACC_END;
        end
      end
      macc_pkg::ACC_END: state_d = macc_pkg::IDLE;
      default: state_d = macc_pkg::IDLE;
    endcase
  end

  // ------------------------------
  // pad address counters
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_a <= '0;
      cnt_b <= '0;
    end else begin
      case (state_q)
        macc_pkg::MUL_RUN: cnt_a <= a_at_len ? '0 : cnt_a + 1'b1; // cnt_b held
        macc_pkg::MUL_END: cnt_b <= b_at_filt ? '0 : cnt_b + 1'b1; // next filter
        macc_pkg::ACC_RUN: cnt_a <= a_at_filt ? '0 : cnt_a + 1'b1; // channel index
        default: begin
          cnt_a <= '0;
          cnt_b <= '0;
        end
      endcase
    end
  end

  // ------------------------------
  // issue tags, straight from state
  // ------------------------------
  assign mul_enable = (state_q == macc_pkg::MUL_RUN);
  assign acc_enable = (state_q == macc_pkg::ACC_RUN);

  assign issue = mul_enable | acc_enable;
  assign issue_acc = acc_enable;

  // every psum addition is a complete sum on its own
  assign issue_first = mul_enable ? (cnt_a == '0) : acc_enable;
  assign issue_last = mul_enable ? a_at_len : acc_enable;
  assign issue_end = (mul_enable & a_at_len & b_at_filt) | (acc_enable & a_at_filt);

endmodule

`default_nettype wire

/* hdl/operand_stage.sv */
// ------------------------------
// pad data must be valid READ_LATENCY cycles after the issue cycle
// operands are registered one cycle later, together with their tags
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "macc_consts.svh"

module operand_stage (
  input logic clk,
  input logic rst_n,
  input logic issue,
  input logic issue_first,
  input logic issue_last,
  input logic issue_acc,
  input logic issue_end,
  input macc_pkg::data_t weight_in,
  input macc_pkg::data_t ifmap_in,
  input macc_pkg::data_t external_psum,
  input macc_pkg::acc_t internal_psum,
  output logic op_valid,
  output logic op_first,
  output logic op_last,
  output logic op_acc,
  output logic op_end,
  output macc_pkg::data_t op_weight,
  output macc_pkg::data_t op_ifmap,
  output macc_pkg::data_t op_ext_psum,
  output macc_pkg::acc_t op_int_psum
);

  // {valid, first, last, acc, end}
  logic [4:0] tag_pipe [`MACC_READ_LATENCY];
  logic [4:0] tag_out;
  logic mul_hit; // product operands are on the pads
  logic acc_hit; // psum operands are on the pads

  // ------------------------------
  // tag delay line, one slot per item in flight
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `MACC_READ_LATENCY; i++) begin
        tag_pipe[i] <= '0;
      end
    end else begin
      tag_pipe[0] <= {issue, issue_first, issue_last, issue_acc, issue_end};
      for (int i = 1; i < `MACC_READ_LATENCY; i++) begin
        tag_pipe[i] <= tag_pipe[i-1];
      end
    end
  end

  assign tag_out = tag_pipe[`MACC_READ_LATENCY-1];
  assign mul_hit = tag_out[4] & ~tag_out[1];
  assign acc_hit = tag_out[4] & tag_out[1];

  // ------------------------------
  // operand capture
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {op_valid, op_first, op_last, op_acc, op_end} <= '0;
    end else begin
      {op_valid, op_first, op_last, op_acc, op_end} <= tag_out;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_hit) begin
      op_weight <= weight_in;
      op_ifmap <= ifmap_in;
    end
    if (acc_hit) begin
      op_ext_psum <= external_psum; // psum pair for channel cnt_a
      op_int_psum <= internal_psum;
    end
  end

endmodule

`default_nettype wire

/* hdl/macc_unit.sv */
// ------------------------------
// products: store 2 cycles after op_valid, psum adds: 1 cycle
// finish pulses 1 cycle after the store of the item tagged op_end
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "macc_consts.svh"

module macc_unit (
  input logic clk,
  input logic rst_n,
  input logic op_valid,
  input logic op_first,
  input logic op_last,
  input logic op_acc,
  input logic op_end,
  input macc_pkg::data_t op_weight,
  input macc_pkg::data_t op_ifmap,
  input macc_pkg::data_t op_ext_psum,
  input macc_pkg::acc_t op_int_psum,
  output macc_pkg::acc_t accum_out,
  output logic psum_store,
  output logic mac_finish,
  output logic acc_finish
);

  logic signed [2*`MACC_DATA_WIDTH-1:0] prod_q; // full-width product
  logic mul_valid;
  logic mul_first;
  logic mul_last;
  logic mul_end;
  logic add_hit; // psum pair this cycle
  logic store_end; // pending store closes the run
  logic store_acc; // pending store came from a psum add

  assign add_hit = op_valid & op_acc;

  // ------------------------------
  // multiply stage
  // ------------------------------
  always_ff @(posedge clk) begin
    if (op_valid && !op_acc) begin
      prod_q <= op_weight * op_ifmap; // signed x signed
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {mul_valid, mul_first, mul_last, mul_end} <= '0;
    end else begin
      mul_valid <= op_valid & ~op_acc;
      mul_first <= op_first;
      mul_last <= op_last;
      mul_end <= op_end;
    end
  end

  // ------------------------------
  // accumulate / psum add stage
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      accum_out <= '0;
    end else if (add_hit) begin
      accum_out <= macc_pkg::acc_t'(op_ext_psum) + op_int_psum; // sign-extended external
    end else if (mul_valid) begin
      if (mul_first) begin
        accum_out <= macc_pkg::acc_t'(prod_q); // new sum starts here
      end else begin
        accum_out <= accum_out + macc_pkg::acc_t'(prod_q);
      end
    end
  end

  // ------------------------------
  // store strobe and finish flags
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      psum_store <= 1'b0;
      store_end <= 1'b0;
      store_acc <= 1'b0;
      mac_finish <= 1'b0;
      acc_finish <= 1'b0;
    end else begin
      psum_store <= add_hit | (mul_valid & mul_last);
      store_end <= (add_hit & op_end) | (mul_valid & mul_last & mul_end);
      store_acc <= add_hit;
      mac_finish <= psum_store & store_end & ~store_acc;
      acc_finish <= psum_store & store_end & store_acc;
    end
  end

endmodule

`default_nettype wire

/* hdl/macc_control_top.sv */
// ------------------------------
// pads are external, data returns READ_LATENCY cycles after cnt_a/cnt_b
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "macc_consts.svh"

module macc_control_top (
  input logic clk,
  input logic rst_n,
  input logic mac_begin,
  input logic acc_begin,
  input macc_pkg::len_t conv_len,
  input macc_pkg::filt_t filter_num,
  input macc_pkg::data_t weight_in,
  input macc_pkg::data_t ifmap_in,
  input macc_pkg::data_t external_psum,
  input macc_pkg::acc_t internal_psum,
  output logic mul_enable,
  output logic acc_enable,
  output macc_pkg::len_t cnt_a,
  output macc_pkg::filt_t cnt_b,
  output macc_pkg::acc_t accum_out,
  output logic psum_store,
  output logic mac_finish,
  output logic acc_finish
);

  // ------------------------------
  // sequencer to operand stage
  // ------------------------------
  logic issue;
  logic issue_first;
  logic issue_last;
  logic issue_acc;
  logic issue_end;

  // ------------------------------
  // operand stage to MAC
  // ------------------------------
  logic op_valid;
  logic op_first;
  logic op_last;
  logic op_acc;
  logic op_end;
  macc_pkg::data_t op_weight;
  macc_pkg::data_t op_ifmap;
  macc_pkg::data_t op_ext_psum;
  macc_pkg::acc_t op_int_psum;

  psum_sequencer u_seq (
    .clk (clk),
    .rst_n (rst_n),
    .mac_begin (mac_begin),
    .acc_begin (acc_begin),
    .conv_len (conv_len),
    .filter_num (filter_num),
    .issue (issue),
    .issue_first (issue_first),
    .issue_last (issue_last),
    .issue_acc (issue_acc),
    .issue_end (issue_end),
    .mul_enable (mul_enable),
    .acc_enable (acc_enable),
    .cnt_a (cnt_a),
    .cnt_b (cnt_b)
  );

  operand_stage u_ops (
    .clk (clk),
    .rst_n (rst_n),
    .issue (issue),
    .issue_first (issue_first),
    .issue_last (issue_last),
    .issue_acc (issue_acc),
    .issue_end (issue_end),
    .weight_in (weight_in),
    .ifmap_in (ifmap_in),
    .external_psum (external_psum),
    .internal_psum (internal_psum),
    .op_valid (op_valid),
    .op_first (op_first),
    .op_last (op_last),
    .op_acc (op_acc),
    .op_end (op_end),
    .op_weight (op_weight),
    .op_ifmap (op_ifmap),
    .op_ext_psum (op_ext_psum),
    .op_int_psum (op_int_psum)
  );

  macc_unit u_mac (
    .clk (clk),
    .rst_n (rst_n),
    .op_valid (op_valid),
    .op_first (op_first),
    .op_last (op_last),
    .op_acc (op_acc),
    .op_end (op_end),
    .op_weight (op_weight),
    .op_ifmap (op_ifmap),
    .op_ext_psum (op_ext_psum),
    .op_int_psum (op_int_psum),
    .accum_out (accum_out),
    .psum_store (psum_store),
    .mac_finish (mac_finish),
    .acc_finish (acc_finish)
  );

endmodule

`default_nettype wire

/* sim/macc_control_tb.sv */
// ------------------------------
// pad models return data 2 cycles after cnt_a/cnt_b
// internal psums are kept within 34 bits so the expected sums never wrap
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module macc_control_tb;

  // sweep cycles are filter_num*(conv_len+1) plus a 16 cycle margin per run
  localparam int total_cycles = 20 + (3*6 + 16) + (1*2 + 16) + (15*16 + 16) + (4 + 16)
                                + (2*5 + 16) + (4 + 16) + 40;

  logic clk;
  logic rst_n;
  logic mac_begin;
  logic acc_begin;
  macc_pkg::len_t conv_len;
  macc_pkg::filt_t filter_num;
  macc_pkg::data_t weight_in;
  macc_pkg::data_t ifmap_in;
  macc_pkg::data_t external_psum;
  macc_pkg::acc_t internal_psum;
  logic mul_enable;
  logic acc_enable;
  macc_pkg::len_t cnt_a;
  macc_pkg::filt_t cnt_b;
  macc_pkg::acc_t accum_out;
  logic psum_store;
  logic mac_finish;
  logic acc_finish;

  macc_pkg::data_t weight_mem [16][16]; // [filter][position]
  macc_pkg::data_t ifmap_mem [16];
  macc_pkg::data_t ext_mem [16];
  macc_pkg::acc_t int_mem [16];
  macc_pkg::data_t w_p1;
  macc_pkg::data_t x_p1;
  macc_pkg::data_t e_p1;
  macc_pkg::acc_t i_p1;

  logic signed [63:0] store_q [$]; // accum_out at each psum_store
  int mac_count;
  int acc_count;
  int mul_cycles;
  int acc_cycles;
  int stores_at_finish;

  macc_control_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // pad models with a 2-stage read pipe
  // ------------------------------
  always @(posedge clk) begin
    w_p1 <= weight_mem[cnt_b][cnt_a];
    x_p1 <= ifmap_mem[cnt_a];
    e_p1 <= ext_mem[cnt_a]; // channel index
    i_p1 <= int_mem[cnt_a];
    weight_in <= w_p1;
    ifmap_in <= x_p1;
    external_psum <= e_p1;
    internal_psum <= i_p1;
  end

  // monitor samples on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (psum_store) store_q.push_back(accum_out);
      if (mac_finish || acc_finish) stores_at_finish = store_q.size();
      if (mac_finish) mac_count++;
      if (acc_finish) acc_count++;
      if (mul_enable) mul_cycles++;
      if (acc_enable) acc_cycles++;
    end
  end

  initial begin
    #(total_cycles * 4 * 8);
    $display("timeout: the DUT never raised its finish flag in the allowed time");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string what, input logic signed [63:0] actual,
                             input logic signed [63:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic longint sweep_sum(input int b, input int len);
    longint sum;
    sum = 0;
    for (int a = 0; a < len; a++) begin
      sum += longint'(weight_mem[b][a]) * longint'(ifmap_mem[a]);
    end
    return sum;
  endfunction

  task automatic fill_random_pads();
    int r;
    for (int i = 0; i < 16; i++) begin
      for (int j = 0; j < 16; j++) weight_mem[i][j] = macc_pkg::data_t'($urandom);
      ifmap_mem[i] = macc_pkg::data_t'($urandom);
      ext_mem[i] = macc_pkg::data_t'($urandom);
      r = $urandom;
      int_mem[i] = longint'(r) * 4; // fits in 34 bits
    end
  endtask

  task automatic pulse_begin(input logic mac, input logic acc);
    @(posedge clk);
    mac_begin <= mac;
    acc_begin <= acc;
    @(posedge clk);
    mac_begin <= 1'b0;
    acc_begin <= 1'b0;
  endtask

  task automatic start_run(input int len, input int filt, input logic acc);
    store_q.delete();
    mac_count = 0;
    acc_count = 0;
    mul_cycles = 0;
    acc_cycles = 0;
    stores_at_finish = -1;
    @(posedge clk);
    conv_len <= macc_pkg::len_t'(len);
    filter_num <= macc_pkg::filt_t'(filt);
    pulse_begin(!acc, acc);
  endtask

  // wait for the finish flag and let the pipeline drain
  task automatic check_run(input int len, input int filt, input logic acc);
    longint exp;
    do @(negedge clk); while (!(acc ? acc_finish : mac_finish));
    repeat (6) @(posedge clk);
    check_value("store count", store_q.size(), filt);
    check_value("stores seen before finish", stores_at_finish, filt);
    check_value("mac_finish pulses", mac_count, acc ? 0 : 1);
    check_value("acc_finish pulses", acc_count, acc ? 1 : 0);
    check_value("mul_enable cycles", mul_cycles, acc ? 0 : len * filt);
    check_value("acc_enable cycles", acc_cycles, acc ? filt : 0);
    for (int i = 0; i < filt; i++) begin
      if (acc) exp = longint'(ext_mem[i]) + longint'(int_mem[i]);
      else exp = sweep_sum(i, len);
      check_value($sformatf("result %0d", i), store_q[i], exp);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_state();
    @(negedge clk);
    check_value("mul_enable after reset", mul_enable, 0);
    check_value("acc_enable after reset", acc_enable, 0);
    check_value("psum_store after reset", psum_store, 0);
    check_value("mac_finish after reset", mac_finish, 0);
    check_value("acc_finish after reset", acc_finish, 0);
    check_value("cnt_a after reset", cnt_a, 0);
    check_value("cnt_b after reset", cnt_b, 0);
  endtask

  task automatic conv_sweep();
    fill_random_pads();
    start_run(5, 3, 1'b0);
    check_run(5, 3, 1'b0);
  endtask

  task automatic edge_lengths();
    start_run(1, 1, 1'b0);
    check_run(1, 1, 1'b0);
    for (int i = 0; i < 16; i++) begin
      for (int j = 0; j < 16; j++) weight_mem[i][j] = 16'sh8000;
      ifmap_mem[i] = 16'sh8000; // largest product magnitude
    end
    start_run(15, 15, 1'b0);
    check_run(15, 15, 1'b0);
  endtask

  task automatic psum_accumulate();
    fill_random_pads();
    start_run(0, 4, 1'b1);
    check_run(0, 4, 1'b1);
  endtask

  task automatic ignored_begin();
    fill_random_pads();
    start_run(4, 2, 1'b0);
    repeat (2) @(posedge clk);
    pulse_begin(1'b0, 1'b1); // lands mid-run
    pulse_begin(1'b1, 1'b0);
    check_run(4, 2, 1'b0);
    pulse_begin(1'b1, 1'b1);
    repeat (20) begin
      @(negedge clk);
      check_value("mul_enable after double begin", mul_enable, 0);
      check_value("acc_enable after double begin", acc_enable, 0);
      check_value("psum_store after double begin", psum_store, 0);
    end
  endtask

  initial begin
    void'($urandom(32'h93dc_84b5));
    rst_n = 1'b0;
    mac_begin = 1'b0;
    acc_begin = 1'b0;
    conv_len = '0;
    filter_num = '0;
    weight_in = '0;
    ifmap_in = '0;
    external_psum = '0;
    internal_psum = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    reset_state();
    conv_sweep();
    edge_lengths();
    psum_accumulate();
    ignored_begin();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/macc_pkg.sv
hdl/psum_sequencer.sv
hdl/operand_stage.sv
hdl/macc_unit.sv
hdl/macc_control_top.sv
sim/macc_control_tb.sv

/* Bender.yml */
package:
  name: macc_control

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/macc_pkg.sv
      - hdl/psum_sequencer.sv
      - hdl/operand_stage.sv
      - hdl/macc_unit.sv
      - hdl/macc_control_top.sv
  - target: simulation
    files:
      - sim/macc_control_tb.sv
